// ==== sources.f ====
design/prefetch_pkg.sv
design/fetch_fsm.sv
design/fetch_fifo.sv
design/instr_aligner.sv
design/prefetch_buffer.sv
test/instr_mem_model.sv
test/prefetch_buffer_sva.sv
test/tb_prefetch_buffer.sv

// ==== test/tb_prefetch_buffer.sv ====
// testbench for the instruction prefetch buffer
// directed tests that check every transfer against a halfword walk of the
// memory image starting at the reset or branch address

module tb_prefetch_buffer;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FIFO_DEPTH = 4;
  localparam int IMG_WORDS  = 256;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      req_i;
  logic                      branch_i;
  prefetch_pkg::word_t       branch_addr_i;
  logic                      ready_i = 1'b0;
  logic                      valid_o;
  prefetch_pkg::instr_out_t  instr_o;
  logic                      instr_req_o;
  prefetch_pkg::word_t       instr_addr_o;
  logic                      instr_gnt_i;
  prefetch_pkg::instr_word_u instr_rdata_i;
  logic                      instr_rvalid_i;
  logic                      busy_o;

  // memory image of 1 KB from address 0
  prefetch_pkg::word_t image [IMG_WORDS];
  prefetch_pkg::word_t image_addr;
  prefetch_pkg::word_t image_data;
  logic                gnt_stall = 1'b0;
  logic [1:0]          rvalid_delay = 2'd0;

  // per-test stimulus modes
  logic        rand_mode = 1'b0;
  logic        ready_ctl = 1'b0;
  logic [1:0]  delay_ctl = 2'd0;
  logic [31:0] stim_seed = 32'hc1ab_e525;
  logic [31:0] fill_seed = 32'hc1ab_e525;

  int                  errors = 0;
  int                  seq_errors = 0;
  int                  timeouts = 0;
  int                  xfer_count = 0;
  int                  gnt_count = 0;
  prefetch_pkg::word_t exp_addr = '0;
  // address the next granted fetch should carry
  prefetch_pkg::word_t fetch_addr = '0;

  prefetch_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .ready_i        (ready_i),
    .valid_o        (valid_o),
    .instr_o        (instr_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  instr_mem_model i_instr_mem_model (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_req_i    (instr_req_o),
    .instr_addr_i   (instr_addr_o),
    .gnt_stall_i    (gnt_stall),
    .rvalid_delay_i (rvalid_delay),
    .image_data_i   (image_data),
    .image_addr_o   (image_addr),
    .instr_gnt_o    (instr_gnt_i),
    .instr_rdata_o  (instr_rdata_i),
    .instr_rvalid_o (instr_rvalid_i)
  );

  assign image_data = image[image_addr[9:2]];

  always #20 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // 32-bit LCG step
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic prefetch_pkg::half_t half_at(input prefetch_pkg::word_t a);
    prefetch_pkg::word_t w;
    w = image[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // low opcode bits both set mark a 32-bit instruction
  function automatic bit is_compressed(input prefetch_pkg::word_t a);
    prefetch_pkg::half_t h;
    h = half_at(a);
    return h[1:0] != 2'b11;
  endfunction

  function automatic prefetch_pkg::instr_out_t ref_instr(input prefetch_pkg::word_t a);
    prefetch_pkg::instr_out_t r;
    r.addr  = a;
    r.rdata = {half_at(a + 32'd2), half_at(a)};
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  // only the low half counts for a compressed instruction
  task automatic check_instr(input prefetch_pkg::instr_out_t got,
                             input prefetch_pkg::instr_out_t exp, input bit half_only);
    prefetch_pkg::word_t mask;
    mask = half_only ? 32'h0000_ffff : 32'hffff_ffff;
    if (got.addr !== exp.addr || (got.rdata & mask) !== (exp.rdata & mask)) begin
      seq_errors++;
      $display("Error: instr_o addr %h rdata %h, expected addr %h rdata %h",
               got.addr, got.rdata & mask, exp.addr, exp.rdata & mask);
    end
  endtask

  task automatic check_word(input string name, input prefetch_pkg::word_t got,
                            input prefetch_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and transfer monitor
  //////////////////////////////////////////////////////////////////////

  // ready and memory delays that are random or fixed per test
  always @(posedge clk) begin
    stim_seed = lcg_step(stim_seed);
    if (rand_mode) begin
      ready_i      <= stim_seed[16];
      gnt_stall    <= stim_seed[20];
      rvalid_delay <= stim_seed[25:24];
    end else begin
      ready_i      <= ready_ctl;
      gnt_stall    <= 1'b0;
      rvalid_delay <= delay_ctl;
    end
  end

  // mid-cycle sample of what the next edge transfers
  always @(negedge clk) begin : transfer_monitor
    bit                  half_only;
    prefetch_pkg::word_t exp_fetch;
    if (!rst_n) begin
      exp_addr   = '0;
      fetch_addr = '0;
      xfer_count = 0;
      gnt_count  = 0;
    end else begin
      // a granted fetch goes to the branch target or to the next word
      if (instr_req_o && instr_gnt_i) begin
        gnt_count++;
        exp_fetch = branch_i ? branch_addr_i : fetch_addr;
        check_word("instr_addr_o", instr_addr_o, exp_fetch);
        fetch_addr = {exp_fetch[31:2], 2'b00} + 32'd4;
      end else if (branch_i) begin
        fetch_addr = branch_addr_i;
      end
      if (valid_o && ready_i) begin
        half_only = is_compressed(exp_addr);
        check_instr(instr_o, ref_instr(exp_addr), half_only);
        exp_addr = exp_addr + (half_only ? 32'd2 : 32'd4);
        xfer_count++;
      end
      // instruction accepted with the branch still belongs to the old path
      if (branch_i) begin
        exp_addr = branch_addr_i;
      end
    end
  end

  // mixed image gets random halves with about half the words forced to 32-bit
  task automatic fill_image(input bit mixed);
    for (int i = 0; i < IMG_WORDS; i++) begin
      fill_seed = lcg_step(fill_seed);
      if (mixed) begin
        image[i] = (fill_seed ^ (i * 32'h0001_0004)) | (fill_seed[7] ? 32'h0003_0003 : 32'h0);
      end else begin
        image[i] = ((i * 4) * 32'h0101_0101 ^ 32'h5a5a_0000) | 32'h3;
      end
    end
  endtask

  task automatic restart_dut(input bit mixed, input logic ready_level);
    @(posedge clk);
    rst_n     <= 1'b0;
    req_i     <= 1'b0;
    branch_i  <= 1'b0;
    rand_mode <= 1'b0;
    ready_ctl <= ready_level;
    delay_ctl <= 2'd0;
    fill_image(mixed);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_xfers(input int n, input int limit);
    int target;
    int cycles;
    target = xfer_count + n;
    cycles = 0;
    while (xfer_count < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (xfer_count < target) begin
      timeouts++;
      $display("Timeout: %0d of %0d transfers seen after %0d cycles",
               n - (target - xfer_count), n, limit);
    end
  endtask

  task automatic wait_grant(input int limit);
    int start;
    int cycles;
    start  = gnt_count;
    cycles = 0;
    while (gnt_count == start && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (gnt_count == start) begin
      timeouts++;
      $display("Timeout: no memory grant within %0d cycles", limit);
    end
  endtask

  task automatic branch_to(input prefetch_pkg::word_t target);
    branch_i      <= 1'b1;
    branch_addr_i <= target;
    @(posedge clk);
    branch_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    restart_dut(1'b0, 1'b1);
    repeat (6) begin
      @(negedge clk);
      check_bit("instr_req_o", instr_req_o, 1'b0);
      check_bit("valid_o", valid_o, 1'b0);
      check_bit("busy_o", busy_o, 1'b0);
    end
  endtask

  task automatic sequential_words();
    restart_dut(1'b0, 1'b1);
    req_i <= 1'b1;
    wait_xfers(20, 300);
  endtask

  task automatic mixed_lengths();
    restart_dut(1'b1, 1'b1);
    req_i <= 1'b1;
    wait_xfers(40, 400);
  endtask

  task automatic branch_redirect();
    restart_dut(1'b1, 1'b1);
    req_i <= 1'b1;
    wait_xfers(6, 100);
    // halfword target mid-stream
    branch_to(32'h0000_0106);
    wait_xfers(8, 150);
    // slow rvalid so the branch lands while a word is in flight
    delay_ctl <= 2'd2;
    repeat (2) @(posedge clk);
    wait_grant(50);
    branch_to(32'h0000_0242);
    wait_xfers(8, 200);
  endtask

  task automatic random_stalls();
    restart_dut(1'b1, 1'b1);
    rand_mode <= 1'b1;
    req_i     <= 1'b1;
    wait_xfers(40, 1500);
    branch_to(32'h0000_0082);
    wait_xfers(40, 1500);
  endtask

  task automatic back_pressure();
    restart_dut(1'b1, 1'b0);
    req_i <= 1'b1;
    repeat (40) @(posedge clk);
    if (gnt_count > FIFO_DEPTH) begin
      errors++;
      $display("Error: instr_gnt_i count %h under back-pressure, limit %h",
               gnt_count, FIFO_DEPTH);
    end
    @(negedge clk);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("valid_o", valid_o, 1'b1);
    @(posedge clk);
    ready_ctl <= 1'b1;
    wait_xfers(20, 300);
  endtask

  initial begin
    rst_n         = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    idle_after_reset();
    sequential_words();
    mixed_lengths();
    branch_redirect();
    random_stalls();
    back_pressure();
    $display("errors: signal %0d, sequence %0d, assertion %0d, timeouts %0d", errors,
             seq_errors, i_prefetch_buffer.i_prefetch_buffer_sva.assert_fails, timeouts);
    if (errors == 0 && seq_errors == 0 && timeouts == 0 &&
        i_prefetch_buffer.i_prefetch_buffer_sva.assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== test/prefetch_buffer_sva.sv ====
// handshake assertions for the prefetch buffer
// memory request hold, output stability under back-pressure, rvalid only
// while a fetch is open

module prefetch_buffer_sva (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        branch_i,
  input logic                        ready_i,
  input logic                        valid_o,
  input prefetch_pkg::instr_out_t    instr_o,
  input logic                        instr_req_o,
  input logic                        instr_gnt_i,
  input logic                        instr_rvalid_i,
  input prefetch_pkg::fetch_state_e  fsm_state_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // failed assertions, read by the testbench at the end of the run
  int assert_fails = 0;

  // an open request waits for its grant
  req_holds: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o)
    else begin
      assert_fails++;
      $error("instr_req_o dropped before instr_gnt_i");
    end

  // stalled instruction stays put unless a branch flushes it
  instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !branch_i |=> valid_o && $stable(instr_o))
    else begin
      assert_fails++;
      $error("instr_o changed while stalled by ready_i");
    end

  // memory answers only a fetch that was granted
  no_idle_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> fsm_state_i != prefetch_pkg::IDLE)
    else begin
      assert_fails++;
      $error("instr_rvalid_i arrived with the fetch FSM in IDLE");
    end

endmodule

bind prefetch_buffer prefetch_buffer_sva i_prefetch_buffer_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .branch_i       (branch_i),
  .ready_i        (ready_i),
  .valid_o        (valid_o),
  .instr_o        (instr_o),
  .instr_req_o    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .fsm_state_i    (i_fetch_fsm.state_q)
);

// ==== test/instr_mem_model.sv ====
// instruction memory responder
// grants requests after an optional stall and returns the word from the
// testbench image one or more cycles later, one access in flight at a time

module instr_mem_model (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       instr_req_i,
  input  prefetch_pkg::word_t        instr_addr_i,
  input  logic                       gnt_stall_i,
  input  logic [1:0]                 rvalid_delay_i,
  input  prefetch_pkg::word_t        image_data_i,
  output prefetch_pkg::word_t        image_addr_o,
  output logic                       instr_gnt_o,
  output prefetch_pkg::instr_word_u  instr_rdata_o,
  output logic                       instr_rvalid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic                pending_q;
  logic [1:0]          wait_q;
  prefetch_pkg::word_t addr_q;

  // data returns once the delay count has run out
  assign instr_rvalid_o = pending_q && (wait_q == 2'd0);

  // a new grant is allowed in the cycle the previous word returns
  assign instr_gnt_o = instr_req_i && !gnt_stall_i && (!pending_q || instr_rvalid_o);

  assign image_addr_o       = addr_q;
  assign instr_rdata_o.raw  = image_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
      wait_q    <= 2'd0;
      addr_q    <= '0;
    end else if (instr_gnt_o) begin
      pending_q <= 1'b1;
      wait_q    <= rvalid_delay_i;
      addr_q    <= instr_addr_i;
    end else if (instr_rvalid_o) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      wait_q <= wait_q - 2'd1;
    end
  end

endmodule

// ==== design/prefetch_buffer.sv ====
// instruction prefetch buffer top
// fetch FSM feeds the word FIFO, the aligner serves the core one
// instruction per valid/ready handshake

module prefetch_buffer #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // core side
  input  logic                       req_i,
  input  logic                       branch_i,
  input  prefetch_pkg::word_t        branch_addr_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output prefetch_pkg::instr_out_t   instr_o,
  // instruction memory
  output logic                       instr_req_o,
  output prefetch_pkg::word_t        instr_addr_o,
  input  logic                       instr_gnt_i,
  input  prefetch_pkg::instr_word_u  instr_rdata_i,
  input  logic                       instr_rvalid_i,
  output logic                       busy_o
);

  logic                     fifo_space;
  logic                     fifo_push;
  logic                     fifo_clear;
  prefetch_pkg::fetch_rsp_t fifo_push_data;
  prefetch_pkg::head_view_t fifo_head;
  prefetch_pkg::advance_e   head_advance;

  // memory side
  fetch_fsm i_fetch_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .space_i        (fifo_space),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .push_o         (fifo_push),
    .push_data_o    (fifo_push_data),
    .clear_o        (fifo_clear),
    .busy_o         (busy_o)
  );

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (fifo_clear),
    .push_i      (fifo_push),
    .push_data_i (fifo_push_data),
    .advance_i   (head_advance),
    .space_o     (fifo_space),
    .head_o      (fifo_head)
  );

  // core side
  instr_aligner i_instr_aligner (
    .head_i    (fifo_head),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .instr_o   (instr_o),
    .advance_o (head_advance)
  );

endmodule

// ==== design/instr_aligner.sv ====
// instruction aligner
// forms one instruction from the two head words, handles compressed
// and halfword-aligned instructions, and tells the FIFO how to move

module instr_aligner (
  input  prefetch_pkg::head_view_t  head_i,
  input  logic                      ready_i,
  output logic                      valid_o,
  output prefetch_pkg::instr_out_t  instr_o,
  output prefetch_pkg::advance_e    advance_o
);

  prefetch_pkg::instr_word_u w0;
  prefetch_pkg::instr_word_u w1;
  prefetch_pkg::half_t       first_half;
  prefetch_pkg::word_t       rdata;
  logic                      offset_hi;
  logic                      compressed;
  logic                      transfer;

  assign w0        = head_i.word0;
  assign w1        = head_i.word1;
  assign offset_hi = head_i.addr[1];

  ////////////////////////////////////////////////////////////////////
  // instruction select
  ////////////////////////////////////////////////////////////////////

  // the halfword the instruction starts with
  assign first_half = offset_hi ? w0.halves.hi : w0.halves.lo;

  // 32-bit instructions have both low opcode bits set
  assign compressed = (first_half[1:0] != 2'b11);

  always_comb begin
    if (compressed) begin
      // upper half zeroed, keeps the output stable while word1 fills
      rdata   = {{prefetch_pkg::HALF_W{1'b0}}, first_half};
      valid_o = head_i.valid0;
    end else if (offset_hi) begin
      // spans two words
      rdata   = {w1.halves.lo, w0.halves.hi};
      valid_o = head_i.valid0 && head_i.valid1;
    end else begin
      rdata   = w0.raw;
      valid_o = head_i.valid0;
    end
  end

  assign instr_o = '{addr: head_i.addr, rdata: rdata};

  ////////////////////////////////////////////////////////////////////
  // head movement
  ////////////////////////////////////////////////////////////////////

  assign transfer = valid_o && ready_i;

  always_comb begin
    if (!transfer) begin
      advance_o = prefetch_pkg::ADV_NONE;
    end else if (!offset_hi && compressed) begin
      // second half of the same word is next
      advance_o = prefetch_pkg::ADV_HALF;
    end else if (offset_hi && !compressed) begin
      // consumed the low half of word1 too
      advance_o = prefetch_pkg::ADV_NEXT_HI;
    end else begin
      advance_o = prefetch_pkg::ADV_NEXT_LO;
    end
  end

endmodule

// ==== design/fetch_fifo.sv ====
// fetch FIFO
// queues fetched words and tracks the address of the instruction at
// the head, which moves by a halfword or on to the next word

module fetch_fifo #(
  // at least 3, one slot is kept for the word in flight
  parameter int FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clear_i,
  input  logic                      push_i,
  input  prefetch_pkg::fetch_rsp_t  push_data_i,
  input  prefetch_pkg::advance_e    advance_i,
  output logic                      space_o,
  output prefetch_pkg::head_view_t  head_o
);

  // entry 0 is the oldest word
  prefetch_pkg::instr_word_u data_q [FIFO_DEPTH];
  prefetch_pkg::instr_word_u data_d [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0]     valid_q, valid_d;

  prefetch_pkg::word_t head_addr_q, head_addr_d;
  prefetch_pkg::word_t head_next;
  // head address still to be taken from the next push
  logic                load_addr_q, load_addr_d;
  logic                placed;
  logic                pop;

  assign pop = (advance_i == prefetch_pkg::ADV_NEXT_LO) ||
               (advance_i == prefetch_pkg::ADV_NEXT_HI);

  assign head_next = {head_addr_q[prefetch_pkg::XLEN-1:2], 2'b00} + prefetch_pkg::WORD_STEP;

  // entries fill from 0 upward, so this slot tells the fill level
  assign space_o = ~valid_q[FIFO_DEPTH-2];

  ////////////////////////////////////////////////////////////////////
  // push, pop and head address
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    valid_d     = valid_q;
    data_d      = data_q;
    head_addr_d = head_addr_q;
    load_addr_d = load_addr_q;
    placed      = 1'b0;

    // incoming word takes the first free slot
    if (push_i) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        if (!valid_q[i] && !placed) begin
          valid_d[i] = 1'b1;
          data_d[i]  = push_data_i.data;
          placed     = 1'b1;
        end
      end
      if (load_addr_q) begin
        // may start on a halfword
        head_addr_d = push_data_i.addr;
        load_addr_d = 1'b0;
      end
    end

    // drop the head word
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH-1; i++) begin
        valid_d[i] = valid_d[i+1];
        data_d[i]  = data_d[i+1];
      end
      valid_d[FIFO_DEPTH-1] = 1'b0;
    end

    unique case (advance_i)
      prefetch_pkg::ADV_HALF:    head_addr_d = {head_addr_q[prefetch_pkg::XLEN-1:2], 2'b10};
      prefetch_pkg::ADV_NEXT_LO: head_addr_d = head_next;
      prefetch_pkg::ADV_NEXT_HI: head_addr_d = {head_next[prefetch_pkg::XLEN-1:2], 2'b10};
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////

  // clear drops all words and waits for a new head address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= '0;
      head_addr_q <= '0;
      load_addr_q <= 1'b1;
    end else if (clear_i) begin
      valid_q     <= '0;
      load_addr_q <= 1'b1;
    end else begin
      valid_q     <= valid_d;
      head_addr_q <= head_addr_d;
      load_addr_q <= load_addr_d;
    end
  end

  // word storage, qualified by valid_q
  always_ff @(posedge clk) begin
    data_q <= data_d;
  end

  assign head_o = '{addr:   head_addr_q,
                    word0:  data_q[0],
                    word1:  data_q[1],
                    valid0: valid_q[0],
                    valid1: valid_q[1]};

endmodule

// ==== design/fetch_fsm.sv ====
// instruction fetch request FSM
// drives the memory req/gnt/rvalid handshake, keeps the fetch address
// and pushes returned words into the FIFO, dropping aborted ones

module fetch_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_i,
  input  logic                       branch_i,
  input  prefetch_pkg::word_t        branch_addr_i,
  input  logic                       space_i,
  input  logic                       instr_gnt_i,
  input  prefetch_pkg::instr_word_u  instr_rdata_i,
  input  logic                       instr_rvalid_i,
  output logic                       instr_req_o,
  output prefetch_pkg::word_t        instr_addr_o,
  output logic                       push_o,
  output prefetch_pkg::fetch_rsp_t   push_data_o,
  output logic                       clear_o,
  output logic                       busy_o
);

  prefetch_pkg::fetch_state_e state_q, state_d;

  // last issued address, or a target that has not been issued yet
  prefetch_pkg::word_t addr_q, addr_d;
  // set when addr_q is still to be fetched as is, not stepped
  logic                restart_q, restart_d;

  prefetch_pkg::word_t seq_addr;
  logic                can_issue;

  ////////////////////////////////////////////////////////////////////
  // address generation
  ////////////////////////////////////////////////////////////////////

  // next word after the last one, from its aligned address
  assign seq_addr = restart_q ? addr_q
                  : {addr_q[prefetch_pkg::XLEN-1:2], 2'b00} + prefetch_pkg::WORD_STEP;

  // a branch clears the FIFO, so space is only needed for sequential fetch
  assign can_issue = req_i && (space_i || branch_i);

  // flush the queue on every branch
  assign clear_o = branch_i;

  ////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    addr_d       = addr_q;
    restart_d    = restart_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_i ? branch_addr_i : seq_addr;
    push_o       = 1'b0;

    unique case (state_q)
      prefetch_pkg::IDLE: begin
        if (can_issue) begin
          instr_req_o = 1'b1;
          addr_d      = instr_addr_o;
          restart_d   = 1'b0;
          state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
        end else if (branch_i) begin
          // keep the target until the core asks for it
          addr_d    = branch_addr_i;
          restart_d = 1'b1;
        end
      end

      prefetch_pkg::WAIT_GNT: begin
        // request holds, only a branch may move the address
        instr_req_o  = 1'b1;
        instr_addr_o = branch_i ? branch_addr_i : addr_q;
        addr_d       = instr_addr_o;
        if (instr_gnt_i) begin
          state_d = prefetch_pkg::WAIT_RVALID;
        end
      end

      prefetch_pkg::WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // word of the current fetch, a clear in this cycle wins in the FIFO
          push_o = 1'b1;
          if (can_issue) begin
            instr_req_o = 1'b1;
            addr_d      = instr_addr_o;
            restart_d   = 1'b0;
            state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
          end else begin
            state_d = prefetch_pkg::IDLE;
            if (branch_i) begin
              addr_d    = branch_addr_i;
              restart_d = 1'b1;
            end
          end
        end else if (branch_i) begin
          // data still in flight belongs to the old path
          addr_d    = branch_addr_i;
          restart_d = 1'b1;
          state_d   = prefetch_pkg::WAIT_ABORTED;
        end
      end

      prefetch_pkg::WAIT_ABORTED: begin
        instr_addr_o = branch_i ? branch_addr_i : addr_q;
        if (branch_i) begin
          addr_d = branch_addr_i;
        end
        // returning word is dropped, then the target is requested
        if (instr_rvalid_i) begin
          if (req_i) begin
            instr_req_o = 1'b1;
            addr_d      = instr_addr_o;
            restart_d   = 1'b0;
            state_d     = instr_gnt_i ? prefetch_pkg::WAIT_RVALID : prefetch_pkg::WAIT_GNT;
          end else begin
            state_d = prefetch_pkg::IDLE;
          end
        end
      end

      default: begin
        state_d = prefetch_pkg::IDLE;
      end
    endcase
  end

  // fetched word goes out with the address it was requested from
  assign push_data_o = '{addr: addr_q, data: instr_rdata_i};

  assign busy_o = (state_q != prefetch_pkg::IDLE) || instr_req_o;

  ////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////

  // after reset the first fetch is at address 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= prefetch_pkg::IDLE;
      addr_q    <= '0;
      restart_q <= 1'b1;
    end else begin
      state_q   <= state_d;
      addr_q    <= addr_d;
      restart_q <= restart_d;
    end
  end

endmodule

// ==== design/prefetch_pkg.sv ====
// prefetch buffer shared types
// word, halfword and instruction word views, stage-to-stage records
// and the state encodings used by the fetch side

package prefetch_pkg;

  // data and address width
  localparam int XLEN = 32;
  localparam int HALF_W = XLEN / 2;

  // byte distance between two fetched words
  localparam logic [XLEN-1:0] WORD_STEP = 32'd4;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [HALF_W-1:0] half_t;

  // one instruction memory word, read whole or as two halfwords
  typedef union packed {
    word_t raw;
    struct packed {
      half_t hi;
      half_t lo;
    } halves;
  } instr_word_u;

  // returned word with the address it was fetched from
  typedef struct packed {
    word_t       addr;
    instr_word_u data;
  } fetch_rsp_t;

  // the two oldest FIFO words plus the current instruction address
  typedef struct packed {
    word_t       addr;
    instr_word_u word0;
    instr_word_u word1;
    logic        valid0;
    logic        valid1;
  } head_view_t;

  // core side instruction
  typedef struct packed {
    word_t addr;
    word_t rdata;
  } instr_out_t;

  // how far the FIFO head moves after a transfer
  typedef enum logic [1:0] {
    ADV_NONE,
    ADV_HALF,
    ADV_NEXT_LO,
    ADV_NEXT_HI
  } advance_e;

  // memory request states
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage
